// ==== Bender.yml ====
package:
  name: rvx_fetch

sources:
  - include_dirs:
      - design
    files:
      - design/rvx_fetch_pkg.sv
      - design/rvx_fifo.sv
      - design/rvx_obi_fetch.sv
      - design/rvx_rvfi_trace.sv
      - design/rvx_fetch_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/rvx_fetch_asserts.sv
      - tb/rvx_fetch_tb.sv

// ==== design/rvx_fetch_macros.svh ====
`ifndef RVX_FETCH_MACROS_SVH
`define RVX_FETCH_MACROS_SVH

//////////////////////////////
// Fetch front end sizing
//////////////////////////////

// First instruction fetched after reset
// Same place the reference core boots from (word address 0x0c00)
`define RVX_BOOT_ADDR 32'h0000_3000

// Granted requests still waiting on rvalid
// Also the depth of the pending-address queue
`define RVX_MAX_OUTSTANDING 2

// Instruction buffer entries
// Total fetch credit, so every request already owns a slot
`define RVX_FETCH_DEPTH 4

//////////////////////////////
// Derived limits
//////////////////////////////

// Byte step between consecutive fetches
`define RVX_FETCH_STEP 32'd4

`endif

// ==== design/rvx_fetch_pkg.sv ====
package rvx_fetch_pkg;

    //////////////////////////////
    // Basic words
    //////////////////////////////

    // Byte address on the instruction port
    typedef logic [31:0] addr_t;

    // Raw 32-bit instruction, no compressed forms
    typedef logic [31:0] insn_t;

    // One fetched word with the address it came from
    typedef struct packed {
        addr_t pc;
        insn_t insn;
    } fetch_entry_t;

    //////////////////////////////
    // OBI instruction port
    //////////////////////////////

    // Address phase, driven by the fetch master
    // rready is not carried, the master always accepts responses
    typedef struct packed {
        logic        req;
        addr_t       addr;
        logic        we;
        logic [3:0]  be;
        logic [31:0] wdata;
    } obi_req_t;

    // Grant and response phase, driven by memory
    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        insn_t rdata;
    } obi_rsp_t;

    //////////////////////////////
    // Retirement trace
    //////////////////////////////

    // Cut-down RVFI record, one per retired word
    typedef struct packed {
        logic [63:0] order;
        addr_t       pc_rdata;
        addr_t       pc_wdata;
        insn_t       insn;
        logic        trap;
    } rvfi_rec_t;

endpackage

// ==== design/rvx_fetch_top.sv ====
`include "rvx_fetch_macros.svh"

module rvx_fetch_top (
    input  logic                    clk_i,
    input  logic                    rst_i,
    output rvx_fetch_pkg::obi_req_t obi_req_o,
    input  rvx_fetch_pkg::obi_rsp_t obi_rsp_i,
    input  logic                    retire_ready_i,
    output logic                    rvfi_valid_o,
    output rvx_fetch_pkg::rvfi_rec_t rvfi_o
);

    import rvx_fetch_pkg::*;

    // Fetch unit to buffer
    logic         fetch_push;
    fetch_entry_t fetch_entry;

    // Buffer to trace stage
    fetch_entry_t buf_head;
    logic         buf_empty;

    // Retire pop, also the credit return
    logic         retire_pop;

    //////////////////////////////
    // OBI fetch master
    //////////////////////////////

    rvx_obi_fetch i_fetch (
        .clk_i        ( clk_i       ),
        .rst_i        ( rst_i       ),
        .obi_req_o    ( obi_req_o   ),
        .obi_rsp_i    ( obi_rsp_i   ),
        .credit_ret_i ( retire_pop  ),
        .push_o       ( fetch_push  ),
        .entry_o      ( fetch_entry )
    );

    //////////////////////////////
    // Instruction buffer
    //////////////////////////////

    // Never overflows, credit reserves a slot before each request
    rvx_fifo #(
        .payload_t ( fetch_entry_t    ),
        .DEPTH     ( `RVX_FETCH_DEPTH )
    ) i_insn_buf (
        .clk_i   ( clk_i       ),
        .rst_i   ( rst_i       ),
        .push_i  ( fetch_push  ),
        .data_i  ( fetch_entry ),
        .pop_i   ( retire_pop  ),
        .data_o  ( buf_head    ),
        .empty_o ( buf_empty   ),
        .full_o  (             )
    );

    //////////////////////////////
    // Retirement trace
    //////////////////////////////

    rvx_rvfi_trace i_trace (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .empty_i        ( buf_empty      ),
        .entry_i        ( buf_head       ),
        .retire_ready_i ( retire_ready_i ),
        .pop_o          ( retire_pop     ),
        .rvfi_valid_o   ( rvfi_valid_o   ),
        .rvfi_o         ( rvfi_o         )
    );

endmodule

// ==== design/rvx_fifo.sv ====
module rvx_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o,
    output logic     full_o
);

    // Pointer and count widths, a single entry still needs one bit
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage, payload only
    payload_t mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic do_push;
    logic do_pop;

    // Full and empty straight from the count
    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));

    // Ignore a push when full or a pop when empty
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Head is always visible, pop only moves the pointer at the edge
    assign data_o = mem_q[rd_ptr_q];

    //////////////////////////////
    // Write side
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    //////////////////////////////
    // Pointers and count
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Wrap explicitly so DEPTH need not be a power of two
            if (do_push) begin
                if (wr_ptr_q == PTR_W'(DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr_q == PTR_W'(DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// ==== design/rvx_obi_fetch.sv ====
`include "rvx_fetch_macros.svh"

module rvx_obi_fetch (
    input  logic                        clk_i,
    input  logic                        rst_i,
    output rvx_fetch_pkg::obi_req_t     obi_req_o,
    input  rvx_fetch_pkg::obi_rsp_t     obi_rsp_i,
    input  logic                        credit_ret_i,
    output logic                        push_o,
    output rvx_fetch_pkg::fetch_entry_t entry_o
);

    import rvx_fetch_pkg::*;

    localparam int OUT_W = $clog2(`RVX_MAX_OUTSTANDING + 1);
    localparam int CRD_W = $clog2(`RVX_FETCH_DEPTH + 1);

    // Next address to request
    addr_t pc_q;

    // Granted but not yet answered
    logic [OUT_W-1:0] outstanding_q;

    // Buffer slots held by requests in flight or entries not yet retired
    logic [CRD_W-1:0] reserved_q;

    logic  req;
    logic  grant;
    logic  resp;
    addr_t pend_addr;

    //////////////////////////////
    // Request decision
    //////////////////////////////

    // Room on the bus and a free slot in the buffer, quiet while in reset
    // Counts only drop while waiting, so req holds until gnt
    assign req = !rst_i
              && (outstanding_q < OUT_W'(`RVX_MAX_OUTSTANDING))
              && (reserved_q < CRD_W'(`RVX_FETCH_DEPTH));

    assign grant = req && obi_rsp_i.gnt;
    assign resp  = obi_rsp_i.rvalid;

    // Read-only port, write fields are fixed
    always_comb begin
        obi_req_o       = '0;
        obi_req_o.req   = req;
        // Address only moves on a grant
        obi_req_o.addr  = pc_q;
        obi_req_o.we    = 1'b0;
        obi_req_o.be    = 4'hF;
        obi_req_o.wdata = '0;
    end

    //////////////////////////////
    // Pending-address queue
    //////////////////////////////

    // Granted addresses in order, responses come back in the same order
    rvx_fifo #(
        .payload_t ( addr_t               ),
        .DEPTH     ( `RVX_MAX_OUTSTANDING )
    ) i_pend_fifo (
        .clk_i   ( clk_i     ),
        .rst_i   ( rst_i     ),
        .push_i  ( grant     ),
        .data_i  ( pc_q      ),
        .pop_i   ( resp      ),
        .data_o  ( pend_addr ),
        .empty_o (           ),
        .full_o  (           )
    );

    // Pair the oldest address with the returned word
    assign push_o       = resp;
    assign entry_o.pc   = pend_addr;
    assign entry_o.insn = obi_rsp_i.rdata;

    //////////////////////////////
    // PC and counters
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q          <= `RVX_BOOT_ADDR;
            outstanding_q <= '0;
            reserved_q    <= '0;
        end else begin
            // No branches, straight-line fetch
            if (grant) begin
                pc_q <= pc_q + `RVX_FETCH_STEP;
            end
            // One up per grant, one down per response
            if (grant && !resp) begin
                outstanding_q <= outstanding_q + 1'b1;
            end else if (resp && !grant) begin
                outstanding_q <= outstanding_q - 1'b1;
            end
            // Credit taken at grant, given back when the trace stage pops
            if (grant && !credit_ret_i) begin
                reserved_q <= reserved_q + 1'b1;
            end else if (credit_ret_i && !grant) begin
                reserved_q <= reserved_q - 1'b1;
            end
        end
    end

endmodule

// ==== design/rvx_rvfi_trace.sv ====
module rvx_rvfi_trace (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        empty_i,
    input  rvx_fetch_pkg::fetch_entry_t entry_i,
    input  logic                        retire_ready_i,
    output logic                        pop_o,
    output logic                        rvfi_valid_o,
    output rvx_fetch_pkg::rvfi_rec_t    rvfi_o
);

    import rvx_fetch_pkg::*;

    // Retirement count, first record gets zero
    logic [63:0] order_q;

    logic      rvfi_valid_q;
    rvfi_rec_t rvfi_q;
    rvfi_rec_t rec_d;

    //////////////////////////////
    // Retire decision
    //////////////////////////////

    // One word per cycle while the outside allows it
    assign pop_o = !empty_i && retire_ready_i;

    //////////////////////////////
    // Record build
    //////////////////////////////

    always_comb begin
        rec_d          = '0;
        rec_d.order    = order_q;
        rec_d.pc_rdata = entry_i.pc;
        // Sequential next PC, nothing redirects fetch
        rec_d.pc_wdata = entry_i.pc + 32'd4;
        rec_d.insn     = entry_i.insn;
        // No C extension, low bits other than 11 are illegal
        rec_d.trap     = (entry_i.insn[1:0] != 2'b11);
    end

    //////////////////////////////
    // Output registers
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvfi_valid_q <= 1'b0;
            order_q      <= '0;
        end else begin
            rvfi_valid_q <= pop_o;
            if (pop_o) begin
                order_q <= order_q + 64'd1;
            end
        end
    end

    // Record contents only matter with valid
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            rvfi_q <= rec_d;
        end
    end

    assign rvfi_valid_o = rvfi_valid_q;
    assign rvfi_o       = rvfi_q;

endmodule

// ==== flist.f ====
+incdir+design
design/rvx_fetch_pkg.sv
design/rvx_fifo.sv
design/rvx_obi_fetch.sv
design/rvx_rvfi_trace.sv
design/rvx_fetch_top.sv
tb/rvx_fetch_asserts.sv
tb/rvx_fetch_tb.sv

// ==== tb/rvx_fetch_asserts.sv ====
`include "rvx_fetch_macros.svh"

module rvx_fetch_asserts (
    input logic                                        clk_i,
    input logic                                        rst_i,
    input rvx_fetch_pkg::obi_req_t                     obi_req_i,
    input rvx_fetch_pkg::obi_rsp_t                     obi_rsp_i,
    input rvx_fetch_pkg::addr_t                        pc_i,
    input logic [$clog2(`RVX_MAX_OUTSTANDING + 1)-1:0] outstanding_i,
    input logic [$clog2(`RVX_FETCH_DEPTH + 1)-1:0]     reserved_i
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////
    // OBI address phase
    //////////////////////////////

    // Request and address frozen until the slave grants
    a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        obi_req_i.req && !obi_rsp_i.gnt |=> obi_req_i.req && $stable(obi_req_i.addr))
        else $error("OBI request dropped or address changed before gnt");

    //////////////////////////////
    // Outstanding bookkeeping
    //////////////////////////////

    // Never more granted requests in flight than the limit
    a_out_limit: assert property (@(posedge clk_i) disable iff (rst_i)
        outstanding_i <= `RVX_MAX_OUTSTANDING)
        else $error("Outstanding OBI requests above the limit");

    // A response always belongs to an earlier grant
    a_rvalid_owned: assert property (@(posedge clk_i) disable iff (rst_i)
        obi_rsp_i.rvalid |-> outstanding_i != '0)
        else $error("OBI rvalid with no request outstanding");

    // Sync reset leaves boot PC and empty counters one cycle later
    a_reset_state: assert property (@(posedge clk_i)
        rst_i |=> pc_i == `RVX_BOOT_ADDR && outstanding_i == '0 && reserved_i == '0)
        else $error("Fetch unit not in its reset state after reset");

endmodule

// Attached to every fetch unit instance
bind rvx_obi_fetch rvx_fetch_asserts i_asserts (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .obi_req_i     ( obi_req_o     ),
    .obi_rsp_i     ( obi_rsp_i     ),
    .pc_i          ( pc_q          ),
    .outstanding_i ( outstanding_q ),
    .reserved_i    ( reserved_q    )
);

// ==== tb/rvx_fetch_tb.sv ====
`include "rvx_fetch_macros.svh"

module rvx_fetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rvx_fetch_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_RECORDS = 200;
    // 20 cycles allowed per record
    localparam int WATCHDOG_NS = NUM_RECORDS * 20 * CLK_PERIOD;

    logic      clk_i;
    logic      rst_i;
    obi_req_t  obi_req;
    obi_rsp_t  obi_rsp;
    logic      retire_ready;
    logic      rvfi_valid;
    rvfi_rec_t rvfi;

    // Memory model, granted addresses and the cycle each answer is due
    addr_t       pend_addr_q [$];
    int unsigned pend_due_q [$];
    int unsigned cyc = 0;

    // Checker state
    int   grant_count = 0;
    int   rec_count   = 0;
    int   trap_count  = 0;
    int   fail_count  = 0;
    logic retire_prev = 1'b0;

    rvx_fetch_top i_dut (
        .clk_i          ( clk_i        ),
        .rst_i          ( rst_i        ),
        .obi_req_o      ( obi_req      ),
        .obi_rsp_i      ( obi_rsp      ),
        .retire_ready_i ( retire_ready ),
        .rvfi_valid_o   ( rvfi_valid   ),
        .rvfi_o         ( rvfi         )
    );

    //////////////////////////////
    // Memory contents and reference
    //////////////////////////////

    // Fixed address hash, roughly one word in four without 11 in bits 1:0
    function automatic insn_t mem_word(input addr_t addr);
        logic [31:0] h;
        h = (addr ^ (addr >> 11)) * 32'h9E37_79B1;
        h = h ^ (h >> 15);
        if (h[5:4] == 2'b00) begin
            return {h[31:2], 1'b0, h[0]};
        end
        return {h[31:2], 2'b11};
    endfunction

    // Record n of a straight-line program starting at the boot address
    function automatic rvfi_rec_t exp_record(input int n);
        rvfi_rec_t rec;
        rec          = '0;
        rec.order    = 64'(n);
        rec.pc_rdata = `RVX_BOOT_ADDR + 32'(n) * 32'd4;
        rec.pc_wdata = rec.pc_rdata + 32'd4;
        rec.insn     = mem_word(rec.pc_rdata);
        // C extension off, anything but 11 traps
        rec.trap     = (rec.insn[1:0] != 2'b11);
        return rec;
    endfunction

    // Word read n on the instruction port, never a write
    function automatic obi_req_t exp_request(input int n);
        obi_req_t fetch_req;
        fetch_req       = '0;
        fetch_req.req   = 1'b1;
        fetch_req.addr  = `RVX_BOOT_ADDR + 32'(n) * 32'd4;
        fetch_req.we    = 1'b0;
        fetch_req.be    = 4'hF;
        fetch_req.wdata = '0;
        return fetch_req;
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic check_addr(input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("Error at %0t: obi_req_o.addr expected %h actual %h", $time, exp, act);
            abort_run();
        end
    endtask

    // Fields shown as req/addr/we/be/wdata
    task automatic check_req(input obi_req_t exp, input obi_req_t act);
        if (act !== exp) begin
            $display("Error at %0t: obi_req_o expected %b/%h/%b/%h/%h actual %b/%h/%b/%h/%h",
                     $time, exp.req, exp.addr, exp.we, exp.be, exp.wdata,
                     act.req, act.addr, act.we, act.be, act.wdata);
            abort_run();
        end
    endtask

    // Fields shown as order/pc_rdata/pc_wdata/insn/trap
    task automatic check_record(input rvfi_rec_t exp, input rvfi_rec_t act);
        if (act !== exp) begin
            $display("Error at %0t: rvfi_o expected %0d/%h/%h/%h/%b actual %0d/%h/%h/%h/%b",
                     $time, exp.order, exp.pc_rdata, exp.pc_wdata, exp.insn, exp.trap,
                     act.order, act.pc_rdata, act.pc_wdata, act.insn, act.trap);
            abort_run();
        end
    endtask

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at %0t: rvfi_valid_o expected %b actual %b", $time, exp, act);
            abort_run();
        end
    endtask

    //////////////////////////////
    // Clock and stimulus
    //////////////////////////////

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    // OBI slave and retire control, sampled at negedge, driven 1 ns after posedge
    initial begin : stimulus
        void'($urandom(8962));
        rst_i        = 1'b1;
        obi_rsp      = '0;
        // Retire allowed in reset, only the reset keeps the trace quiet
        retire_ready = 1'b1;
        repeat (3) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        forever begin
            @(negedge clk_i);
            // Grant taken at the coming edge, answer 0 to 3 cycles later
            if (obi_req.req && obi_rsp.gnt) begin
                pend_addr_q.push_back(obi_req.addr);
                pend_due_q.push_back(cyc + 1 + $urandom_range(3, 0));
            end
            if (obi_rsp.rvalid) begin
                void'(pend_addr_q.pop_front());
                void'(pend_due_q.pop_front());
            end
            @(posedge clk_i);
            #1;
            cyc++;
            obi_rsp.gnt = ($urandom_range(99, 0) < 60);
            // Only the oldest request may answer, keeps order
            if (pend_due_q.size() > 0 && pend_due_q[0] <= cyc) begin
                obi_rsp.rvalid = 1'b1;
                obi_rsp.rdata  = mem_word(pend_addr_q[0]);
            end else begin
                obi_rsp.rvalid = 1'b0;
                obi_rsp.rdata  = '0;
            end
            // Long retire stall in the last 70 of every 250 cycles
            retire_ready = ((cyc % 250) < 180) && ($urandom_range(99, 0) < 70);
        end
    end

    //////////////////////////////
    // Comparison
    //////////////////////////////

    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (obi_req.req && obi_rsp.gnt) begin
                check_addr(`RVX_BOOT_ADDR + 32'(grant_count) * 32'd4, obi_req.addr);
                check_req(exp_request(grant_count), obi_req);
                grant_count++;
            end
            if (rvfi_valid) begin
                // A record here means a pop in the previous cycle
                if (!retire_prev) begin
                    $display("Record retired at %0t while retire_ready_i was low", $time);
                    abort_run();
                end
                check_record(exp_record(rec_count), rvfi);
                if (rvfi.trap) begin
                    trap_count++;
                end
                rec_count++;
            end
            // Requests in flight plus buffered words, bounded by buffer depth
            if (grant_count - rec_count > `RVX_FETCH_DEPTH) begin
                $display("Error at %0t: fetch credit in use expected <= %0d actual %0d",
                         $time, `RVX_FETCH_DEPTH, grant_count - rec_count);
                abort_run();
            end
        end
        retire_prev = retire_ready;
    end

    initial begin : run_control
        obi_req_t idle_req;
        // First reset edge has passed, PC at boot and nothing requested or retired
        @(posedge clk_i);
        @(negedge clk_i);
        idle_req     = exp_request(0);
        idle_req.req = 1'b0;
        check_req(idle_req, obi_req);
        check_valid(1'b0, rvfi_valid);
        wait (rec_count == NUM_RECORDS);
        if (trap_count == 0) begin
            $display("No trapping word retired, trap rule never exercised");
            fail_count++;
        end
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: only %0d of %0d records retired in %0d ns",
                 rec_count, NUM_RECORDS, WATCHDOG_NS);
        abort_run();
    end

endmodule
